/* source/mem_read_pkg.sv */
`default_nettype none

package mem_read_pkg;

    localparam int NUM_CLIENTS = 2;
    localparam int QUEUE_DEPTH = 4;
    localparam int LINE_BYTE_OFFSET = 6;
    localparam int ID_WIDTH = 4;
    localparam int BEAT_BYTES = 4;

    // Derived widths
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
    localparam int ID_SEQ_WIDTH = ID_WIDTH - 1;

    // AXI burst type INCR
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // Client index, also the top bit of the transaction ID
    typedef enum logic {
        CLIENT_INSTR = 1'b0,
        CLIENT_DATA  = 1'b1
    } client_e;

    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_ADDR,
        ISS_DATA
    } issuer_state_e;

    typedef struct packed {
        logic [31:0] startaddr;
        logic [31:0] va;
        logic [7:0]  len;
        logic [2:0]  size;
    } refill_req_t;

    typedef struct packed {
        refill_req_t         req;
        logic [ID_WIDTH-1:0] id;
    } queued_req_t;

    typedef struct packed {
        logic                arvalid;
        logic [ID_WIDTH-1:0] arid;
        logic [31:0]         araddr;
        logic [7:0]          arlen;
        logic [2:0]          arsize;
        logic [1:0]          arburst;
    } axi_ar_t;

    typedef struct packed {
        logic                rvalid;
        logic [ID_WIDTH-1:0] rid;
        logic [31:0]         rdata;
        logic                rlast;
    } axi_r_t;

    typedef struct packed {
        logic        valid;
        client_e     client;
        logic [31:0] addr;
        logic [31:0] va;
        logic [31:0] data;
        logic        last;
    } refill_resp_t;

endpackage

`default_nettype wire

/* source/refill_queue.sv */
`default_nettype none

module refill_queue #(
    parameter mem_read_pkg::client_e CLIENT = mem_read_pkg::CLIENT_INSTR
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_req,
    input  wire mem_read_pkg::refill_req_t i_req_data,
    input  wire logic                      i_pop,
    output logic                           o_ack,
    output mem_read_pkg::queued_req_t      o_head,
    output logic                           o_head_valid,
    output logic                           o_idle
);

    mem_read_pkg::queued_req_t r_mem [mem_read_pkg::QUEUE_DEPTH];

    logic [mem_read_pkg::QUEUE_PTR_WIDTH-1:0] r_wr_ptr;
    logic [mem_read_pkg::QUEUE_PTR_WIDTH-1:0] r_rd_ptr;
    logic [mem_read_pkg::QUEUE_CNT_WIDTH-1:0] r_count;
    logic [mem_read_pkg::ID_SEQ_WIDTH-1:0]    r_id_seq;
    logic                                     r_ack;
    logic                                     w_full;
    logic                                     w_write;
    logic                                     w_read;

    assign w_full = (r_count == mem_read_pkg::QUEUE_CNT_WIDTH'(mem_read_pkg::QUEUE_DEPTH));

    // New request seen while ack is low, held off while full
    assign w_write = i_req && !r_ack && !w_full;
    assign w_read  = i_pop && (r_count != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_ack <= 1'b0;
        end else if (w_write) begin
            r_ack <= 1'b1;
        end else if (!i_req) begin
            // Requester has dropped req, finish the handshake
            r_ack <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
            r_id_seq <= '0;
        end else begin
            if (w_write) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
                r_id_seq <= r_id_seq + 1'b1;
            end
            if (w_read) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            if (w_write && !w_read) begin
                r_count <= r_count + 1'b1;
            end else if (!w_write && w_read) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_write) begin
            r_mem[r_wr_ptr].req <= i_req_data;
            r_mem[r_wr_ptr].id  <= {CLIENT, r_id_seq};
        end
    end

    assign o_ack        = r_ack;
    assign o_head       = r_mem[r_rd_ptr];
    assign o_head_valid = (r_count != '0);
    assign o_idle       = (r_count == '0);

endmodule

`default_nettype wire

/* source/refill_issuer.sv */
`default_nettype none

module refill_issuer (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire mem_read_pkg::queued_req_t   i_heads [mem_read_pkg::NUM_CLIENTS],
    input  wire logic [mem_read_pkg::NUM_CLIENTS-1:0] i_head_valid,
    input  wire logic                        i_write_busy,
    input  wire logic [31:0]                 i_write_addr,
    input  wire logic                        i_axi_arready,
    input  wire mem_read_pkg::axi_r_t        i_axi_r,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_pop,
    output mem_read_pkg::axi_ar_t            o_axi_ar,
    output mem_read_pkg::refill_resp_t       o_resp,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_start,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_end
);

    mem_read_pkg::issuer_state_e r_state;
    mem_read_pkg::issuer_state_e w_next_state;
    mem_read_pkg::client_e       r_sel;
    mem_read_pkg::client_e       w_next_sel;
    mem_read_pkg::queued_req_t   w_head;

    logic [31:0] r_addr;
    logic [31:0] r_va;
    logic        r_end;
    logic        w_hazard;
    logic        w_arvalid;
    logic        w_ar_fire;
    logic        w_r_fire;
    logic        w_r_done;

    assign w_head = i_heads[r_sel];

    // Hold the address phase while a write to the same line is in flight
    assign w_hazard = i_write_busy &&
        (i_write_addr[31:mem_read_pkg::LINE_BYTE_OFFSET] ==
         w_head.req.startaddr[31:mem_read_pkg::LINE_BYTE_OFFSET]);

    assign w_arvalid = (r_state == mem_read_pkg::ISS_ADDR) && !w_hazard;
    assign w_ar_fire = w_arvalid && i_axi_arready;
    assign w_r_fire  = (r_state == mem_read_pkg::ISS_DATA) && i_axi_r.rvalid;
    assign w_r_done  = w_r_fire && i_axi_r.rlast;

    always_comb begin
        w_next_state = r_state;
        w_next_sel   = r_sel;
        case (r_state)
            mem_read_pkg::ISS_IDLE: begin
                // Data side has fixed priority
                if (i_head_valid[mem_read_pkg::CLIENT_DATA]) begin
                    w_next_sel   = mem_read_pkg::CLIENT_DATA;
                    w_next_state = mem_read_pkg::ISS_ADDR;
                end else if (i_head_valid[mem_read_pkg::CLIENT_INSTR]) begin
                    w_next_sel   = mem_read_pkg::CLIENT_INSTR;
                    w_next_state = mem_read_pkg::ISS_ADDR;
                end
            end
            mem_read_pkg::ISS_ADDR: begin
                if (w_ar_fire) begin
                    w_next_state = mem_read_pkg::ISS_DATA;
                end
            end
            mem_read_pkg::ISS_DATA: begin
                if (w_r_done) begin
                    w_next_state = mem_read_pkg::ISS_IDLE;
                end
            end
            default: begin
                w_next_state = mem_read_pkg::ISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state <= mem_read_pkg::ISS_IDLE;
            r_sel   <= mem_read_pkg::CLIENT_INSTR;
            r_end   <= 1'b0;
        end else begin
            r_state <= w_next_state;
            r_sel   <= w_next_sel;
            r_end   <= w_r_done;
        end
    end

    // Running beat addresses, start from the head on the AR handshake
    always_ff @(posedge i_clk) begin
        if (w_ar_fire) begin
            r_addr <= w_head.req.startaddr;
            r_va   <= w_head.req.va;
        end else if (w_r_fire) begin
            r_addr <= r_addr + 32'(mem_read_pkg::BEAT_BYTES);
            r_va   <= r_va + 32'(mem_read_pkg::BEAT_BYTES);
        end
    end

    always_comb begin
        o_axi_ar.arvalid = w_arvalid;
        o_axi_ar.arid    = w_head.id;
        o_axi_ar.araddr  = w_head.req.startaddr;
        o_axi_ar.arlen   = w_head.req.len;
        o_axi_ar.arsize  = w_head.req.size;
        o_axi_ar.arburst = mem_read_pkg::AXI_BURST_INCR;
    end

    always_comb begin
        o_resp.valid  = w_r_fire;
        o_resp.client = r_sel;
        o_resp.addr   = r_addr;
        o_resp.va     = r_va;
        o_resp.data   = i_axi_r.rdata;
        o_resp.last   = i_axi_r.rlast;
    end

    // r_sel still names the finished client in the cycle after rlast
    always_comb begin
        for (int c = 0; c < mem_read_pkg::NUM_CLIENTS; c++) begin
            o_pop[c]   = w_r_done && (r_sel == mem_read_pkg::client_e'(c));
            o_start[c] = w_arvalid && (r_sel == mem_read_pkg::client_e'(c));
            o_end[c]   = r_end && (r_sel == mem_read_pkg::client_e'(c));
        end
    end

endmodule

`default_nettype wire

/* source/mem_read_top.sv */
`default_nettype none

module mem_read_top (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic [mem_read_pkg::NUM_CLIENTS-1:0] i_req,
    input  wire mem_read_pkg::refill_req_t   i_req_data [mem_read_pkg::NUM_CLIENTS],
    input  wire logic                        i_write_busy,
    input  wire logic [31:0]                 i_write_addr,
    input  wire logic                        i_axi_arready,
    input  wire mem_read_pkg::axi_r_t        i_axi_r,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_ack,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_idle,
    output mem_read_pkg::axi_ar_t            o_axi_ar,
    output mem_read_pkg::refill_resp_t       o_resp,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_start,
    output logic [mem_read_pkg::NUM_CLIENTS-1:0] o_end
);

    mem_read_pkg::queued_req_t                w_heads [mem_read_pkg::NUM_CLIENTS];
    logic [mem_read_pkg::NUM_CLIENTS-1:0]     w_head_valid;
    logic [mem_read_pkg::NUM_CLIENTS-1:0]     w_pop;

    // One queue per client, index matches client_e
    for (genvar g = 0; g < mem_read_pkg::NUM_CLIENTS; g++) begin : g_queue
        refill_queue #(
            .CLIENT(mem_read_pkg::client_e'(g))
        ) i_refill_queue (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_req       (i_req[g]),
            .i_req_data  (i_req_data[g]),
            .i_pop       (w_pop[g]),
            .o_ack       (o_ack[g]),
            .o_head      (w_heads[g]),
            .o_head_valid(w_head_valid[g]),
            .o_idle      (o_idle[g])
        );
    end

    refill_issuer i_refill_issuer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_heads      (w_heads),
        .i_head_valid (w_head_valid),
        .i_write_busy (i_write_busy),
        .i_write_addr (i_write_addr),
        .i_axi_arready(i_axi_arready),
        .i_axi_r      (i_axi_r),
        .o_pop        (w_pop),
        .o_axi_ar     (o_axi_ar),
        .o_resp       (o_resp),
        .o_start      (o_start),
        .o_end        (o_end)
    );

endmodule

`default_nettype wire

/* sim/axi_read_slave_model.sv */
`default_nettype none

module axi_read_slave_model (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire mem_read_pkg::axi_ar_t i_ar,
    output logic                       o_arready,
    output mem_read_pkg::axi_r_t       o_r
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rng_state;
    mem_read_pkg::axi_ar_t burst;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        rng_state = 32'h3239;
        o_arready = 1'b0;
        o_r = '0;
        forever begin
            @(posedge i_clk);
            if (!i_rst && i_ar.arvalid) begin
                // Random address phase delay of 0 to 3 cycles
                rng_state = lcg_next(rng_state);
                repeat (int'(rng_state[17:16])) @(posedge i_clk);
                #2 o_arready = 1'b1;
                @(posedge i_clk);
                while (!i_ar.arvalid) @(posedge i_clk);
                burst = i_ar;
                for (int i = 0; i <= int'(burst.arlen); i++) begin
                    #2;
                    o_arready = 1'b0;
                    o_r.rvalid = 1'b1;
                    o_r.rid = burst.arid;
                    o_r.rdata = (burst.araddr + 32'(i * 4)) ^ 32'hA5A5_0000;
                    o_r.rlast = (i == int'(burst.arlen));
                    @(posedge i_clk);
                end
                #2 o_r = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_mem_read.sv */
`default_nettype none

module tb_mem_read;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQS = 43;
    localparam int MAX_BEATS = 8;
    localparam int TIMEOUT_CYCLES = NUM_REQS * MAX_BEATS * 8 + 200;

    logic i_clk;
    logic i_rst;
    logic [1:0] i_req;
    mem_read_pkg::refill_req_t i_req_data [2];
    logic i_write_busy;
    logic [31:0] i_write_addr;
    logic arready;
    mem_read_pkg::axi_r_t axi_r;
    logic [1:0] o_ack;
    logic [1:0] o_idle;
    mem_read_pkg::axi_ar_t o_axi_ar;
    mem_read_pkg::refill_resp_t o_resp;
    logic [1:0] o_start;
    logic [1:0] o_end;

    mem_read_pkg::refill_resp_t exp_q [2][$];
    int ar_order [$];
    int accepted [2];
    int end_count [2];
    int pend [2];
    logic model_busy;
    int cur_client;
    logic [2:0] id_seq [2];
    logic [1:0] prev_req;
    logic [1:0] prev_ack;
    logic [31:0] rng_state;
    int cycles;
    int error_count;
    int n0;

    mem_read_top i_mem_read_top (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req), .i_req_data(i_req_data),
        .i_write_busy(i_write_busy), .i_write_addr(i_write_addr),
        .i_axi_arready(arready), .i_axi_r(axi_r), .o_ack(o_ack), .o_idle(o_idle),
        .o_axi_ar(o_axi_ar), .o_resp(o_resp), .o_start(o_start), .o_end(o_end)
    );

    axi_read_slave_model i_slave (
        .i_clk(i_clk), .i_rst(i_rst), .i_ar(o_axi_ar), .o_arready(arready), .o_r(axi_r)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected beat i of a burst, built from the slave data rule
    function automatic mem_read_pkg::refill_resp_t expected_beat(
        input int client, input mem_read_pkg::refill_req_t req, input int i);
        mem_read_pkg::refill_resp_t beat;
        beat.valid = 1'b1;
        beat.client = mem_read_pkg::client_e'(client);
        beat.addr = req.startaddr + 32'(i * mem_read_pkg::BEAT_BYTES);
        beat.va = req.va + 32'(i * mem_read_pkg::BEAT_BYTES);
        beat.data = beat.addr ^ 32'hA5A5_0000;
        beat.last = (i == int'(req.len));
        return beat;
    endfunction

    task automatic stop_run();
        error_count++;
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic send_request(input int c, input logic [31:0] addr, input logic [31:0] va,
                                input logic [7:0] len);
        mem_read_pkg::refill_req_t req;
        req.startaddr = addr;
        req.va = va;
        req.len = len;
        req.size = 3'd2;
        @(posedge i_clk);
        while (o_ack[c]) @(posedge i_clk);
        #2;
        i_req_data[c] = req;
        i_req[c] = 1'b1;
        @(posedge i_clk);
        while (!o_ack[c]) @(posedge i_clk);
        for (int i = 0; i <= int'(len); i++) begin
            exp_q[c].push_back(expected_beat(c, req, i));
        end
        accepted[c]++;
        #2 i_req[c] = 1'b0;
        @(posedge i_clk);
        while (o_ack[c]) @(posedge i_clk);
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) @(posedge i_clk);
    endtask

    function automatic int rand_below(input int n);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[23:16]) % n;
    endfunction

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // Response comparison, the served client follows a model of the arbitration
    always @(posedge i_clk) begin
        mem_read_pkg::refill_resp_t exp;
        if (!i_rst) begin
            for (int k = 0; k < 2; k++) begin
                if (o_ack[k] && !prev_ack[k]) pend[k]++;
            end
            if (o_resp.valid) begin
                assert (model_busy && exp_q[cur_client].size() != 0) else begin
                    $display("ERROR: response beat at %0t with nothing expected", $time);
                    stop_run();
                end
                exp = exp_q[cur_client].pop_front();
                check_value("o_resp.client", 32'(cur_client), 32'(o_resp.client));
                check_value("o_resp.addr", exp.addr, o_resp.addr);
                check_value("o_resp.va", exp.va, o_resp.va);
                check_value("o_resp.data", exp.data, o_resp.data);
                check_value("o_resp.last", 32'(exp.last), 32'(o_resp.last));
                if (exp.last) begin
                    pend[cur_client]--;
                    model_busy = 1'b0;
                end
            end else if (!model_busy) begin
                // Idle issuer takes data first
                if (pend[1] > 0) begin
                    cur_client = 1;
                    model_busy = 1'b1;
                end else if (pend[0] > 0) begin
                    cur_client = 0;
                    model_busy = 1'b1;
                end
            end
        end
    end

    // AR channel, IDs, write hazard and four-phase order
    always @(posedge i_clk) begin
        int c;
        if (!i_rst) begin
            if (o_axi_ar.arvalid && arready) begin
                c = cur_client;
                check_value("o_start", 32'(1 << c), 32'(o_start));
                check_value("o_axi_ar.arid", 32'({c[0], id_seq[c]}), 32'(o_axi_ar.arid));
                id_seq[c] <= id_seq[c] + 3'd1;
                ar_order.push_back(int'(o_axi_ar.arid[3]));
                assert (!(i_write_busy && i_write_addr[31:6] == o_axi_ar.araddr[31:6])) else begin
                    $display("ERROR: AR handshake to a line under write at %0t", $time);
                    stop_run();
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (o_end[k]) end_count[k]++;
                assert (!(o_ack[k] && !prev_ack[k] && !prev_req[k])) else begin
                    $display("ERROR: ack rose without req on client %0d", k);
                    stop_run();
                end
            end
        end
        prev_req <= i_req;
        prev_ack <= o_ack;
    end

    initial begin
        rng_state = 32'h3239;
        cycles = 0;
        error_count = 0;
        id_seq = '{3'd0, 3'd0};
        accepted = '{0, 0};
        end_count = '{0, 0};
        pend = '{0, 0};
        model_busy = 1'b0;
        cur_client = 0;
        prev_req = '0;
        prev_ack = '0;
        i_rst = 1'b1;
        i_req = '0;
        i_req_data = '{'0, '0};
        i_write_busy = 1'b0;
        i_write_addr = '0;
        repeat (10) @(posedge i_clk);
        #2 i_rst = 1'b0;
        check_value("o_axi_ar.arvalid", 32'd0, 32'(o_axi_ar.arvalid));
        check_value("o_start", 32'd0, 32'(o_start));
        check_value("o_end", 32'd0, 32'(o_end));
        check_value("o_ack", 32'd0, 32'(o_ack));
        check_value("o_resp.valid", 32'd0, 32'(o_resp.valid));
        check_value("o_idle", 32'd3, 32'(o_idle));

        // Single instruction refill
        send_request(0, 32'h0000_1000, 32'h8000_1000, 8'd7);
        wait_drain();
        repeat (3) @(posedge i_clk);
        check_value("o_end count", 32'd1, 32'(end_count[0]));

        // Both clients waiting, data goes first
        for (int r = 0; r < 5; r++) begin
            n0 = ar_order.size();
            fork
                send_request(0, 32'h0000_2000 + 32'(r * 64), 32'h9000_0000 + 32'(r * 64), 8'd3);
                send_request(1, 32'h0001_0000 + 32'(r * 64), 32'hA000_0000 + 32'(r * 64), 8'd3);
            join
            wait_drain();
            check_value("first arid client", 32'd1, 32'(ar_order[n0]));
        end

        // Queue full, issue held by a write to the same line
        #2;
        i_write_busy = 1'b1;
        i_write_addr = 32'h0000_3020;
        n0 = accepted[0];
        fork
            for (int k = 0; k < 6; k++) begin
                send_request(0, 32'h0000_3000, 32'hB000_0000 + 32'(k * 256), 8'd1);
            end
            begin
                while (accepted[0] < n0 + mem_read_pkg::QUEUE_DEPTH) @(posedge i_clk);
                repeat (6) @(posedge i_clk);
                check_value("o_ack", 32'd0, 32'(o_ack[0]));
                check_value("accepted", 32'(n0 + mem_read_pkg::QUEUE_DEPTH), 32'(accepted[0]));
                check_value("o_axi_ar.arvalid", 32'd0, 32'(o_axi_ar.arvalid));
                #2 i_write_busy = 1'b0;
            end
        join
        wait_drain();

        // Write to a different line does not block
        #2;
        i_write_busy = 1'b1;
        i_write_addr = 32'h0000_5000;
        send_request(1, 32'h0000_4000, 32'hC000_0000, 8'd2);
        send_request(0, 32'h0000_4100, 32'hC000_1000, 8'd2);
        wait_drain();
        #2 i_write_busy = 1'b0;

        // Random traffic
        fork
            for (int k = 0; k < 12; k++) begin
                send_request(0, 32'(rand_below(256)) << 6, 32'h1000_0000 + 32'(k * 64),
                             8'(rand_below(MAX_BEATS)));
            end
            for (int k = 0; k < 12; k++) begin
                send_request(1, 32'(rand_below(256)) << 8, 32'h2000_0000 + 32'(k * 64),
                             8'(rand_below(MAX_BEATS)));
            end
        join
        wait_drain();
        repeat (4) @(posedge i_clk);
        check_value("o_idle", 32'd3, 32'(o_idle));
        check_value("o_end count instr", 32'(accepted[0]), 32'(end_count[0]));
        check_value("o_end count data", 32'(accepted[1]), 32'(end_count[1]));

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "errors seen");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
source/mem_read_pkg.sv
source/refill_queue.sv
source/refill_issuer.sv
source/mem_read_top.sv
sim/axi_read_slave_model.sv
sim/tb_mem_read.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mem_read
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
